// File: all.f
amul_pkg.sv
amul_array.sv
amul_err_stats.sv
amul_regs.sv
amul_top.sv
amul_sva.sv
amul_tb.sv

// File: amul_array.sv
`default_nettype none

module amul_array (
    input  wire amul_pkg::operand_t x,
    input  wire amul_pkg::operand_t y,
    output amul_pkg::product_t      approx
);

    // One partial-product row per bit of x, before it is placed at its weight.
    logic [amul_pkg::OPERAND_W-1:0] row [amul_pkg::OPERAND_W];

    // The same rows shifted left by their index into the product width.
    amul_pkg::product_t term [amul_pkg::OPERAND_W];

    // OR of each low row pair, which stands in for a real addition.
    amul_pkg::product_t or_word [amul_pkg::APPROX_PAIRS];

    amul_pkg::product_t sum;

    for (genvar i = 0; i < amul_pkg::OPERAND_W; i++) begin : g_row
        if (i == amul_pkg::OPERAND_MSB) begin : g_sign_row
            // The sign bit of x has negative weight, so the magnitude bits of this
            // row are inverted while the product of the two sign bits stays positive.
            assign row[i] = {
                y[amul_pkg::OPERAND_MSB] & x[i],
                ~(y[amul_pkg::OPERAND_MSB-1:0] & {amul_pkg::OPERAND_MSB{x[i]}})
            };
        end else begin : g_plain_row
            // Only the y sign bit is inverted in an ordinary row.
            assign row[i] = {
                ~(y[amul_pkg::OPERAND_MSB] & x[i]),
                y[amul_pkg::OPERAND_MSB-1:0] & {amul_pkg::OPERAND_MSB{x[i]}}
            };
        end

        assign term[i] = {{amul_pkg::OPERAND_W{1'b0}}, row[i]} << i;
    end

    // Rows (0,1), (2,3) and (4,5) are merged with OR gates. Where both rows of
    // a pair have a one at the same weight the carry is lost, which is the
    // only source of error in this array.
    for (genvar p = 0; p < amul_pkg::APPROX_PAIRS; p++) begin : g_pair
        assign or_word[p] = term[2*p] | term[2*p+1];
    end

    // Exact addition of the compressed words, the upper rows and the
    // correction constants, modulo two to the product width.
    always_comb begin
        sum = amul_pkg::BW_CORRECTION;
        for (int p = 0; p < amul_pkg::APPROX_PAIRS; p++) begin
            sum = sum + or_word[p];
        end
        for (int i = amul_pkg::APPROX_ROWS; i < amul_pkg::OPERAND_W; i++) begin
            sum = sum + term[i];
        end
    end

    assign approx = sum;

endmodule

`default_nettype wire

// File: amul_err_stats.sv
`default_nettype none

module amul_err_stats (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire amul_pkg::operand_t x,
    input  wire amul_pkg::operand_t y,
    input  wire amul_pkg::product_t approx,
    input  wire logic               sample,
    input  wire logic               clear,
    output amul_pkg::product_t      exact,
    output amul_pkg::err_t          err_sum,
    output amul_pkg::err_t          err_max,
    output amul_pkg::count_t        count
);

    amul_pkg::product_t             diff;
    amul_pkg::err_t                 abs_err;
    logic [amul_pkg::PRODUCT_W:0]   sum_ext;
    amul_pkg::err_t                 sum_next;

    // Both operands are signed, so they are sign-extended to the product width.
    assign exact = x * y;

    assign diff = exact - approx;

    // The most negative difference maps to its true magnitude as an unsigned word.
    assign abs_err = diff[amul_pkg::PRODUCT_W-1] ? -diff : diff;

    assign sum_ext = {1'b0, err_sum} + {1'b0, abs_err};

    // The sum sticks at all ones once it overflows.
    assign sum_next = sum_ext[amul_pkg::PRODUCT_W] ? '1 : sum_ext[amul_pkg::PRODUCT_W-1:0];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            err_sum <= '0;
            err_max <= '0;
            count   <= '0;
        end else if (sample) begin
            err_sum <= sum_next;
            if (abs_err > err_max) begin
                err_max <= abs_err;
            end
            // count wraps, no saturation here
            count <= count + amul_pkg::count_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: amul_pkg.sv
`default_nettype none

package amul_pkg;

    localparam int OPERAND_W = 16;
    localparam int OPERAND_MSB = OPERAND_W - 1;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // Low multiplier bits whose rows are OR-compressed in pairs.
    localparam int APPROX_ROWS = 6;
    localparam int APPROX_PAIRS = APPROX_ROWS / 2;

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic [PRODUCT_W-1:0] err_t;
    typedef logic [31:0] count_t;
    typedef logic [2:0] wb_adr_t;
    typedef logic [31:0] wb_data_t;

    // Baugh-Wooley correction constants, a one at bit 16 and a one at bit 31.
    localparam product_t BW_CORRECTION = 32'h8001_0000;

    localparam wb_adr_t ADR_OPERANDS = 3'd0;
    localparam wb_adr_t ADR_RESULT = 3'd1;
    localparam wb_adr_t ADR_EXACT = 3'd2;
    localparam wb_adr_t ADR_ERR_SUM = 3'd3;
    localparam wb_adr_t ADR_ERR_MAX = 3'd4;
    localparam wb_adr_t ADR_COUNT = 3'd5;
    localparam wb_adr_t ADR_CTRL = 3'd6;

    // Bit of the CTRL word that clears the statistics.
    localparam int CTRL_CLEAR_BIT = 0;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_data_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: amul_regs.sv
`default_nettype none

module amul_regs (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire amul_pkg::wb_req_t  wb_req,
    output amul_pkg::wb_rsp_t       wb_rsp,
    input  wire amul_pkg::product_t approx,
    input  wire amul_pkg::product_t exact,
    input  wire amul_pkg::err_t     err_sum,
    input  wire amul_pkg::err_t     err_max,
    input  wire amul_pkg::count_t   count,
    output amul_pkg::operand_t      x,
    output amul_pkg::operand_t      y,
    output logic                    sample,
    output logic                    clear
);

    logic               ack;
    logic               access;
    logic               wr_ack;
    logic               wr_operands;
    logic               wr_clear;
    amul_pkg::wb_data_t rd_data;

    // A new access is one that is not already being acknowledged.
    assign access = wb_req.cyc & wb_req.stb & ~ack;

    // Writes commit on the edge that ends the ack cycle.
    assign wr_ack = ack & wb_req.cyc & wb_req.stb & wb_req.we;

    assign wr_operands = wr_ack && (wb_req.adr == amul_pkg::ADR_OPERANDS);
    assign wr_clear = wr_ack && (wb_req.adr == amul_pkg::ADR_CTRL)
                      && wb_req.dat_w[amul_pkg::CTRL_CLEAR_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            ack    <= 1'b0;
            sample <= 1'b0;
            clear  <= 1'b0;
        end else begin
            ack    <= access;
            sample <= wr_operands;
            clear  <= wr_clear;
        end
    end

    // The x operand sits in the low half of the word and y in the high half.
    always_ff @(posedge clk) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else if (wr_operands) begin
            {y, x} <= wb_req.dat_w;
        end
    end

    // Read data is taken from the live values during the ack cycle, so the
    // statistics updated by a previous sample pulse are already visible.
    always_comb begin
        case (wb_req.adr)
            amul_pkg::ADR_OPERANDS: begin
                rd_data = {y, x};
            end
            amul_pkg::ADR_RESULT: begin
                rd_data = approx;
            end
            amul_pkg::ADR_EXACT: begin
                rd_data = exact;
            end
            amul_pkg::ADR_ERR_SUM: begin
                rd_data = err_sum;
            end
            amul_pkg::ADR_ERR_MAX: begin
                rd_data = err_max;
            end
            amul_pkg::ADR_COUNT: begin
                rd_data = count;
            end
            default: begin
                // CTRL and the unmapped address read as zero.
                rd_data = '0;
            end
        endcase
    end

    assign wb_rsp = '{ack: ack, dat_r: rd_data};

endmodule

`default_nettype wire

// File: amul_sva.sv
`default_nettype none

module amul_regs_sva (
    input wire logic              clk,
    input wire logic              rst,
    input wire amul_pkg::wb_req_t wb_req,
    input wire amul_pkg::wb_rsp_t wb_rsp,
    input wire logic              sample,
    input wire logic              clear
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // An ack only answers a live request.
    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fail_count++;
            $error("ack high without cyc and stb");
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_count++;
            $error("ack held for two cycles");
        end

    pulses_low_in_reset: assert property (@(posedge clk)
        rst |=> (!sample && !clear))
        else begin
            fail_count++;
            $error("sample or clear high during reset");
        end

    // One write addresses either OPERANDS or CTRL, never both.
    pulses_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(sample && clear))
        else begin
            fail_count++;
            $error("sample and clear high together");
        end

endmodule

bind amul_regs amul_regs_sva u_sva (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .sample (sample),
    .clear  (clear)
);

`default_nettype wire

// File: amul_tb.sv
`default_nettype none

module amul_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_TIMEOUT = 20;
    localparam int RANDOM_PAIRS = 300;

    typedef enum logic [1:0] {
        KIND_PRODUCT,
        KIND_ERR,
        KIND_COUNT,
        KIND_WORD
    } kind_t;

    logic              clk;
    logic              rst;
    amul_pkg::wb_req_t wb_req;
    amul_pkg::wb_rsp_t wb_rsp;

    int unsigned errors;
    logic [31:0] lfsr_state;

    // Operands as last written, and the statistics the DUT should hold.
    amul_pkg::operand_t cur_x;
    amul_pkg::operand_t cur_y;
    amul_pkg::err_t     shadow_sum;
    amul_pkg::err_t     shadow_max;
    amul_pkg::count_t   shadow_count;

    // Read results waiting for the compare process.
    kind_t               kind_q [$];
    string               name_q [$];
    amul_pkg::wb_data_t  exp_q [$];
    amul_pkg::wb_data_t  act_q [$];
    event                result_ready;

    amul_top u_amul_top (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Right-shifting Galois LFSR with taps at 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_operand(output amul_pkg::operand_t value);
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[b] = lfsr_state[0];
        end
    endtask

    function automatic amul_pkg::operand_t corner_operand(input int idx);
        case (idx)
            0: return 16'h0000;
            1: return 16'h0001;
            2: return 16'hffff;
            3: return 16'h7fff;
            default: return 16'h8000;
        endcase
    endfunction

    // Baugh-Wooley rows built one at a time. The low row pairs are merged
    // with OR, everything else is added exactly.
    function automatic amul_pkg::product_t ref_approx(input amul_pkg::operand_t x,
                                                      input amul_pkg::operand_t y);
        logic [15:0]        row;
        amul_pkg::product_t term [16];
        amul_pkg::product_t acc;
        for (int i = 0; i < 16; i++) begin
            if (i == 15) begin
                row[14:0] = ~(y[14:0] & {15{x[i]}});
                row[15] = y[15] & x[i];
            end else begin
                row[14:0] = y[14:0] & {15{x[i]}};
                row[15] = ~(y[15] & x[i]);
            end
            term[i] = {16'h0000, row} << i;
        end
        acc = (32'd1 << 16) + (32'd1 << 31);
        for (int i = 0; i < 16; i++) begin
            if (i >= amul_pkg::APPROX_ROWS) begin
                acc = acc + term[i];
            end else if (i % 2 == 0) begin
                acc = acc + (term[i] | term[i+1]);
            end
        end
        return acc;
    endfunction

    function automatic amul_pkg::product_t exact_product(input amul_pkg::operand_t x,
                                                         input amul_pkg::operand_t y);
        return int'(x) * int'(y);
    endfunction

    function automatic amul_pkg::err_t abs_error(input amul_pkg::product_t exact,
                                                 input amul_pkg::product_t approx);
        amul_pkg::product_t diff;
        diff = exact - approx;
        return diff[31] ? -diff : diff;
    endfunction

    function automatic string reg_name(input amul_pkg::wb_adr_t adr);
        case (adr)
            amul_pkg::ADR_OPERANDS: return "OPERANDS";
            amul_pkg::ADR_RESULT: return "RESULT";
            amul_pkg::ADR_EXACT: return "EXACT";
            amul_pkg::ADR_ERR_SUM: return "ERR_SUM";
            amul_pkg::ADR_ERR_MAX: return "ERR_MAX";
            amul_pkg::ADR_COUNT: return "COUNT";
            amul_pkg::ADR_CTRL: return "CTRL";
            default: return "UNMAPPED";
        endcase
    endfunction

    task automatic clear_shadow();
        shadow_sum = '0;
        shadow_max = '0;
        shadow_count = '0;
    endtask

    task automatic update_shadow(input amul_pkg::operand_t x, input amul_pkg::operand_t y);
        amul_pkg::err_t abs_err;
        logic [32:0]    sum_ext;
        abs_err = abs_error(exact_product(x, y), ref_approx(x, y));
        sum_ext = {1'b0, shadow_sum} + {1'b0, abs_err};
        shadow_sum = sum_ext[32] ? '1 : sum_ext[31:0];
        if (abs_err > shadow_max) begin
            shadow_max = abs_err;
        end
        shadow_count = shadow_count + 1;
    endtask

    // One classic single cycle. The request is held until ack is seen on a
    // falling edge and dropped on the edge that ends the ack cycle.
    task automatic bus_cycle(input logic we, input amul_pkg::wb_adr_t adr,
                             input amul_pkg::wb_data_t dat_w,
                             output amul_pkg::wb_data_t dat_r, output logic ok);
        amul_pkg::wb_req_t req;
        int                waited;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        req.dat_w = dat_w;
        ok = 1'b0;
        dat_r = '0;
        waited = 0;
        @(posedge clk);
        wb_req <= req;
        while (!ok && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            if (wb_rsp.ack === 1'b1) begin
                ok = 1'b1;
                dat_r = wb_rsp.dat_r;
            end
            waited++;
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input amul_pkg::wb_adr_t adr, input amul_pkg::wb_data_t data);
        amul_pkg::wb_data_t unused;
        logic               ok;
        bus_cycle(1'b1, adr, data, unused, ok);
        if (!ok) begin
            errors++;
            $display("Write to address %0d was not acknowledged within %0d cycles",
                     adr, ACK_TIMEOUT);
        end
    endtask

    task automatic wb_read(input amul_pkg::wb_adr_t adr, output amul_pkg::wb_data_t data,
                           output logic ok);
        bus_cycle(1'b0, adr, '0, data, ok);
        if (!ok) begin
            errors++;
            $display("Read from address %0d was not acknowledged within %0d cycles",
                     adr, ACK_TIMEOUT);
        end
    endtask

    task automatic read_and_expect(input kind_t kind, input amul_pkg::wb_adr_t adr,
                                   input amul_pkg::wb_data_t expected);
        amul_pkg::wb_data_t data;
        logic               ok;
        wb_read(adr, data, ok);
        if (ok) begin
            kind_q.push_back(kind);
            name_q.push_back(reg_name(adr));
            exp_q.push_back(expected);
            act_q.push_back(data);
            -> result_ready;
        end
    endtask

    task automatic write_operands(input amul_pkg::operand_t x, input amul_pkg::operand_t y);
        wb_write(amul_pkg::ADR_OPERANDS, {y, x});
        cur_x = x;
        cur_y = y;
        update_shadow(x, y);
    endtask

    // Reads back every result register and queues it against the model.
    task automatic check_state();
        read_and_expect(KIND_WORD, amul_pkg::ADR_OPERANDS, {cur_y, cur_x});
        read_and_expect(KIND_PRODUCT, amul_pkg::ADR_RESULT, ref_approx(cur_x, cur_y));
        read_and_expect(KIND_PRODUCT, amul_pkg::ADR_EXACT, exact_product(cur_x, cur_y));
        read_and_expect(KIND_ERR, amul_pkg::ADR_ERR_SUM, shadow_sum);
        read_and_expect(KIND_ERR, amul_pkg::ADR_ERR_MAX, shadow_max);
        read_and_expect(KIND_COUNT, amul_pkg::ADR_COUNT, shadow_count);
    endtask

    task automatic check_product(input string name, input amul_pkg::product_t expected,
                                 input amul_pkg::product_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_err(input string name, input amul_pkg::err_t expected,
                             input amul_pkg::err_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input amul_pkg::count_t expected,
                               input amul_pkg::count_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input amul_pkg::wb_data_t expected,
                              input amul_pkg::wb_data_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    initial begin
        kind_t              kind;
        string              name;
        amul_pkg::wb_data_t expected;
        amul_pkg::wb_data_t actual;
        forever begin
            @(result_ready);
            while (kind_q.size() > 0) begin
                kind = kind_q.pop_front();
                name = name_q.pop_front();
                expected = exp_q.pop_front();
                actual = act_q.pop_front();
                case (kind)
                    KIND_PRODUCT: check_product(name, expected, actual);
                    KIND_ERR: check_err(name, expected, actual);
                    KIND_COUNT: check_count(name, expected, actual);
                    default: check_word(name, expected, actual);
                endcase
            end
        end
    end

    initial begin
        amul_pkg::operand_t rx;
        amul_pkg::operand_t ry;
        int unsigned        sva_fails;
        int                 drain_wait;
        errors = 0;
        lfsr_state = 32'h19d5;
        cur_x = '0;
        cur_y = '0;
        clear_shadow();
        rst = 1'b1;
        wb_req = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Every address, the unmapped one included, reads as zero after reset.
        for (int a = 0; a < 8; a++) begin
            read_and_expect(KIND_WORD, amul_pkg::wb_adr_t'(a), '0);
        end

        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                write_operands(corner_operand(i), corner_operand(j));
                check_state();
            end
        end

        repeat (RANDOM_PAIRS) begin
            random_operand(rx);
            random_operand(ry);
            write_operands(rx, ry);
            check_state();
        end

        wb_write(amul_pkg::ADR_CTRL, 32'h0000_0001);
        clear_shadow();
        check_state();
        // RESULT is read only, so this write must leave everything alone.
        wb_write(amul_pkg::ADR_RESULT, 32'hdead_beef);
        check_state();
        random_operand(rx);
        random_operand(ry);
        write_operands(rx, ry);
        check_state();

        drain_wait = 0;
        while (kind_q.size() > 0 && drain_wait < ACK_TIMEOUT) begin
            @(negedge clk);
            drain_wait++;
        end
        if (kind_q.size() > 0) begin
            errors++;
            $display("Compare process left %0d results unchecked", kind_q.size());
        end

        sva_fails = u_amul_top.u_regs.u_sva.fail_count;
        $display("Summary: %0d check errors, %0d assertion failures", errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: amul_top.sv
`default_nettype none

module amul_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire amul_pkg::wb_req_t wb_req,
    output wire amul_pkg::wb_rsp_t wb_rsp
);

    wire amul_pkg::operand_t x;
    wire amul_pkg::operand_t y;
    wire amul_pkg::product_t approx;
    wire amul_pkg::product_t exact;
    wire amul_pkg::err_t     err_sum;
    wire amul_pkg::err_t     err_max;
    wire amul_pkg::count_t   count;
    wire logic               sample;
    wire logic               clear;

    // Bus side. Holds the operands and turns writes into sample and clear pulses.
    amul_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .approx  (approx),
        .exact   (exact),
        .err_sum (err_sum),
        .err_max (err_max),
        .count   (count),
        .x       (x),
        .y       (y),
        .sample  (sample),
        .clear   (clear)
    );

    amul_array u_array (
        .x      (x),
        .y      (y),
        .approx (approx)
    );

    // Accuracy monitor, compares the array output against the exact product.
    amul_err_stats u_stats (
        .clk     (clk),
        .rst     (rst),
        .x       (x),
        .y       (y),
        .approx  (approx),
        .sample  (sample),
        .clear   (clear),
        .exact   (exact),
        .err_sum (err_sum),
        .err_max (err_max),
        .count   (count)
    );

endmodule

`default_nettype wire
